/* filelist.f */
verilog/radarPkg.sv
verilog/azimuthGen.sv
verilog/masterTrigger.sv
verilog/noiseGen.sv
verilog/clutterVideo.sv
verilog/dacSerializer.sv
verilog/radarTop.sv
verif/radar_props.sv
verif/clockGen.sv
verif/radarTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the radar simulator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module radarTb -f filelist.f -o radarSim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/radarSim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

/* verif/clockGen.sv */
// ##########################################################################
// testbench clock, 10 ns period, power-on reset for 8 cycles
// ##########################################################################
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rst
);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  initial
  begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* verif/radarTb.sv */
// ##########################################################################
// radar simulator testbench, free run plus a late reset, checked by bound props
// ##########################################################################
`timescale 1ns/1ps

module radarTb
  import radarPkg::*;
;

  localparam int acpPer = 40;
  localparam int azBits = 2;
  localparam int trigPer = 120;
  localparam int timeoutCycles = 4 * acpPer * (2 ** azBits) + 160; // 4 revolutions

  logic clk, porRst, extraRst, rst;
  logic acp, arp, trig, dacCs, dacSclk, dacSdi, dacClr;
  videoT video;
  int cycles = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int lastFails = 0;

  assign rst = porRst | extraRst;

  clockGen uClock (.clk(clk), .rst(porRst));

  radarTop #(
    .acpPeriod(acpPer), .acpHigh(4), .azimuthBits(azBits), .trigPeriod(trigPer), .trigHigh(10)
  ) DUT (
    .clk(clk), .rst(rst), .acp(acp), .arp(arp), .trig(trig), .video(video),
    .dacCs(dacCs), .dacSclk(dacSclk), .dacSdi(dacSdi), .dacClr(dacClr)
  );

  task automatic finishTest(input string name);
    int newFails;
    newFails = DUT.props.failCount - lastFails;
    lastFails = DUT.props.failCount;
    testsRun++;
    if (newFails > 0)
    begin
      testsFailed++;
      $display("test %s: %0d assertion failures", name, newFails);
    end
    else
      $display("test %s: passed", name);
  endtask

  task automatic waitArp();
    @(posedge clk);
    while (!arp)
      @(posedge clk);
  endtask

  initial
  begin
    extraRst = 1'b0;
    while (porRst)
      @(posedge clk);
    waitArp();
    finishTest("reset values and first ARP");
    repeat (2 * trigPer + 20) @(posedge clk);
    finishTest("ACP, trigger, video and DAC frames");
    extraRst <= 1'b1; // late reset
    repeat (3) @(posedge clk);
    extraRst <= 1'b0;
    waitArp();
    repeat (2 * trigPer + 20) @(posedge clk);
    finishTest("late reset and rearm");
    $display("tests %0d, failed %0d, assertion failures %0d",
      testsRun, testsFailed, DUT.props.failCount);
    if (testsFailed == 0 && DUT.props.failCount == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= timeoutCycles)
    begin
      $display("timeout, the run did not finish within %0d cycles", timeoutCycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

/* verif/radar_props.sv */
// ##########################################################################
// timing and data rules of the radar simulator, bound onto radarTop
// ##########################################################################
`timescale 1ns/1ps

module radarProps
  import radarPkg::*;
#(
  parameter int acpPeriod = 40,
  parameter int acpHigh = 4,
  parameter int azimuthBits = 2,
  parameter int trigPeriod = 120,
  parameter int trigHigh = 10
) (
  input logic  clk,
  input logic  rst,
  input logic  acp,
  input logic  arp,
  input logic  trig,
  input videoT video,
  input logic  dacCs,
  input logic  dacSclk,
  input logic  dacSdi,
  input logic  dacClr
);

  int failCount = 0; // read by the testbench
  logic prevAcp, prevTrig, prevCs, prevSclk;
  logic firstCycle, seenArp, trigStarted, framed;
  int acpAge, acpRises, trigAge, sinceFall, csLow, csHigh, bitIdx;
  videoT prevVideo;
  dacWordT expWord;
  logic acpRise, trigRise, csFall, csRise, sclkRise;
  int acpNow, trigNow;

  assign acpRise = acp & ~prevAcp;
  assign trigRise = trig & ~prevTrig;
  assign csFall = ~dacCs & prevCs;
  assign csRise = dacCs & ~prevCs;
  assign sclkRise = dacSclk & ~prevSclk;
  assign acpNow = acpRise ? 0 : acpAge;   // cycles since the ACP rise
  assign trigNow = trigRise ? 0 : trigAge;

  // lowest outline level a range bin can fall to
  function automatic int minLevel(input int bin);
    int lvl;
    lvl = int'(outlineLevels[0]);
    for (int i = 0; i < outlinePoints; i++)
    begin
      if (bin >= int'(outlineBins[i]))
        lvl = int'(outlineLevels[i]);
    end
    return lvl;
  endfunction

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      prevAcp <= 1'b1;
      prevTrig <= 1'b0;
      prevCs <= 1'b1;
      prevSclk <= 1'b0;
      firstCycle <= 1'b1;
      seenArp <= 1'b0;
      trigStarted <= 1'b0;
      framed <= 1'b0;
      acpAge <= 0;
      acpRises <= 0;
      trigAge <= 0;
      sinceFall <= 1 << 20; // no pulse yet, far range
      csLow <= 0;
      csHigh <= 0;
      bitIdx <= 0;
      prevVideo <= '0;
      expWord <= '0;
    end
    else
    begin
      prevAcp <= acp;
      prevTrig <= trig;
      prevCs <= dacCs;
      prevSclk <= dacSclk;
      prevVideo <= video;
      firstCycle <= 1'b0;
      seenArp <= seenArp | arp;
      acpAge <= acpNow + 1;
      trigAge <= trigNow + 1;
      if (acpRise)
        acpRises <= acpRises + 1;
      if (trigRise)
        trigStarted <= 1'b1;
      if (trig)
        sinceFall <= 0;
      else if (sinceFall < (1 << 20))
        sinceFall <= sinceFall + 1;
      csLow <= dacCs ? 0 : csLow + 1;
      csHigh <= dacCs ? csHigh + 1 : 0;
      if (csRise)
        framed <= 1'b1;
      if (csFall)
      begin
        expWord <= {8'h3F, prevVideo, 4'h0}; // video seen at the cs edge
        bitIdx <= 23;
      end
      else if (sclkRise)
        bitIdx <= bitIdx - 1;
    end
  end

  assert property (@(posedge clk) firstCycle && !rst |->
    acp && !arp && !trig && dacCs && !dacSclk && video == '0)
  else
  begin
    $error("outputs are wrong right after reset");
    failCount++;
  end

  // DAC clear follows the system reset, also while reset is high
  assert property (@(posedge clk) dacClr == rst)
  else
  begin
    $error("Fail dacClr %h expected %h", dacClr, rst);
    failCount++;
  end

  assert property (@(posedge clk) disable iff (rst)
    (acp == (acpNow < acpHigh)) && (!acpRise || acpAge == acpPeriod))
  else
  begin
    $error("ACP pulse width or period is wrong");
    failCount++;
  end

  assert property (@(posedge clk) disable iff (rst)
    (!arp || acp) && (!acpRise || arp == (acpRises % (1 << azimuthBits) == 0)))
  else
  begin
    $error("ARP is not on every revolution start");
    failCount++;
  end

  assert property (@(posedge clk) disable iff (rst)
    (!trig || seenArp) && (!trigRise || !trigStarted || trigAge == trigPeriod)
    && (!trigStarted || trig == (trigNow < trigHigh)))
  else
  begin
    $error("trigger timing is wrong");
    failCount++;
  end

  assert property (@(posedge clk) disable iff (rst)
    trig && trigNow >= 3 |-> video == 12'hFFF)
  else
  begin
    $error("Fail video %h during trigger, expected fff", video);
    failCount++;
  end

  assert property (@(posedge clk) disable iff (rst)
    !trig |-> int'(video) >= minLevel(sinceFall / 2 + 2)
      && (sinceFall < 4 || sinceFall > 23 || video >= 12'd3000))
  else
  begin
    $error("Fail video %h below clutter outline", video);
    failCount++;
  end

  assert property (@(posedge clk) disable iff (rst)
    (!csRise || csLow == 2 * dacFrameBits) && (!csFall || !framed || csHigh == 2))
  else
  begin
    $error("DAC chip select timing is wrong");
    failCount++;
  end

  assert property (@(posedge clk) disable iff (rst) sclkRise |-> dacSdi == expWord[bitIdx])
  else
  begin
    $error("Fail dacSdi %h expected word %h bit %0d", dacSdi, expWord, bitIdx);
    failCount++;
  end

endmodule

bind radarTop radarProps #(
  .acpPeriod   (acpPeriod),
  .acpHigh     (acpHigh),
  .azimuthBits (azimuthBits),
  .trigPeriod  (trigPeriod),
  .trigHigh    (trigHigh)
) props (
  .clk     (clk),
  .rst     (rst),
  .acp     (acp),
  .arp     (arp),
  .trig    (trig),
  .video   (video),
  .dacCs   (dacCs),
  .dacSclk (dacSclk),
  .dacSdi  (dacSdi),
  .dacClr  (dacClr)
);

/* verilog/azimuthGen.sv */
// ##########################################################################
// ACP pulse train with azimuth count and ARP on the zero position
// ##########################################################################
`timescale 1ns/1ps

module azimuthGen #(
  parameter int acpPeriod = 24413,
  parameter int acpHigh = 245,
  parameter int azimuthBits = 12
) (
  input  logic clk,
  input  logic rst,
  output logic acp,
  output logic arp
);

  localparam int cntW = $clog2(acpPeriod);

  logic [cntW-1:0] periodCnt;
  logic [azimuthBits-1:0] azimuth;
  logic periodEnd;

  assign periodEnd = (periodCnt == cntW'(acpPeriod - 1));

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      periodCnt <= '0;
      acp <= 1'b1;    // pulse already high out of reset
      azimuth <= '1;  // first rise after release lands on zero
    end
    else if (periodEnd)
    begin
      periodCnt <= '0;
      acp <= 1'b1;
      azimuth <= azimuth + 1'b1; // wraps at 2^azimuthBits
    end
    else
    begin
      periodCnt <= periodCnt + 1'b1;
      if (periodCnt == cntW'(acpHigh - 1))
        acp <= 1'b0;
    end
  end

  assign arp = acp & (azimuth == '0);

endmodule

/* verilog/clutterVideo.sv */
// ##########################################################################
// 12-bit sea clutter video, outline by range band plus attenuated noise
// one sample every second cycle, full scale while the trigger is high
// ##########################################################################
`timescale 1ns/1ps

module clutterVideo
  import radarPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  trig,
  output videoT video
);

  logic step;       // video clock enable
  rangeBinT rangeBin;
  noiseT noise;
  noiseT attNoise;
  logic [3:0] band;
  videoT level;
  logic [12:0] sum; // extra bit catches overflow

  noiseGen uNoise (
    .clk   (clk),
    .rst   (rst),
    .step  (step),
    .noise (noise)
  );

  // highest breakpoint already passed
  always_comb
  begin
    band = '0;
    for (int i = 1; i < outlinePoints; i++)
    begin
      if (rangeBin >= outlineBins[i])
        band = 4'(i);
    end
  end

  assign level = outlineLevels[band];
  assign attNoise = noise >> bandShift[band];
  assign sum = {1'b0, level} + {2'b00, attNoise};

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      step <= 1'b0;
      rangeBin <= '0;
      video <= '0;
    end
    else
    begin
      step <= ~step;
      if (step)
      begin
        if (trig)
        begin
          rangeBin <= '0; // range restarts at the end of the pulse
          video <= '1;
        end
        else
        begin
          video <= sum[12] ? '1 : sum[11:0];
          if (rangeBin != '1)
            rangeBin <= rangeBin + 1'b1; // hold at the far end
        end
      end
    end
  end

endmodule

/* verilog/dacSerializer.sv */
// ##########################################################################
// serial DAC frame sender, command, address and one video sample per frame
// ##########################################################################
`timescale 1ns/1ps

module dacSerializer
  import radarPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  videoT video,
  output logic  dacCs,
  output logic  dacSclk,
  output logic  dacSdi
);

  serState state;
  logic [4:0] bitCnt;   // bit index in a frame, gap count when idle
  dacWordT shiftReg;
  logic frameStart;

  assign frameStart = (state == serIdle) && (bitCnt == 5'd1);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= serIdle;
      bitCnt <= 5'd1; // first frame right after release
      dacCs <= 1'b1;
      dacSclk <= 1'b0;
    end
    else
    begin
      case (state)
        serIdle:
        begin
          if (frameStart)
          begin
            dacCs <= 1'b0;
            bitCnt <= '0;
            state <= serLow;
          end
          else
            bitCnt <= bitCnt + 1'b1;
        end
        serLow:
        begin
          dacSclk <= 1'b1; // DAC samples on this rise
          state <= serHigh;
        end
        serHigh:
        begin
          dacSclk <= 1'b0;
          if (bitCnt == 5'(dacFrameBits - 1))
          begin
            dacCs <= 1'b1;
            bitCnt <= '0;
            state <= serIdle;
          end
          else
          begin
            bitCnt <= bitCnt + 1'b1;
            state <= serLow;
          end
        end
        default: state <= serIdle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (frameStart)
      shiftReg <= {dacCmd, dacAddr, video, 4'b0000};
    else if (state == serHigh)
      shiftReg <= shiftReg << 1;
  end

  assign dacSdi = shiftReg[dacFrameBits-1]; // MSB first

endmodule

/* verilog/masterTrigger.sv */
// ##########################################################################
// periodic transmit trigger, held off until the first ARP after reset
// ##########################################################################
`timescale 1ns/1ps

module masterTrigger #(
  parameter int trigPeriod = 24413,
  parameter int trigHigh = 51
) (
  input  logic clk,
  input  logic rst,
  input  logic arp,
  output logic trig
);

  localparam int cntW = $clog2(trigPeriod);

  logic [cntW-1:0] cnt;
  logic armed;
  logic trigReg;
  logic wrap;

  assign wrap = (cnt == cntW'(trigPeriod - 1));

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      armed <= 1'b0;
      cnt <= '0;
      trigReg <= 1'b1; // first pulse goes out as soon as armed
    end
    else
    begin
      if (arp)
        armed <= 1'b1;
      if (armed)
      begin
        cnt <= wrap ? '0 : cnt + 1'b1;
        if (wrap)
          trigReg <= 1'b1;
        else if (cnt == cntW'(trigHigh - 1))
          trigReg <= 1'b0;
      end
    end
  end

  assign trig = armed & trigReg;

endmodule

/* verilog/noiseGen.sv */
// ##########################################################################
// clutter noise source, sum of three LFSRs advanced on each video step
// ##########################################################################
`timescale 1ns/1ps

module noiseGen
  import radarPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  step,
  output noiseT noise
);

  logic [7:0] lfsr8;
  logic [8:0] lfsr9;
  logic [9:0] lfsr10;
  logic [9:0] next8;
  logic [9:0] next9;
  logic [9:0] next10;

  // same tap pattern for every width: top two bits fold in bits 1 and 0,
  // the rest chain on the freshly computed bit two places up
  function automatic logic [9:0] lfsrNext(input logic [9:0] s, input int w);
    logic [9:0] n;
    n = '0;
    for (int i = 9; i >= 0; i--)
    begin
      if (i == w - 1)
        n[i] = s[i] ^ s[1];
      else if (i == w - 2)
        n[i] = s[i] ^ s[0];
      else if (i < w - 2)
        n[i] = s[i] ^ n[i + 2];
    end
    return n;
  endfunction

  assign next8 = lfsrNext({2'b00, lfsr8}, 8);
  assign next9 = lfsrNext({1'b0, lfsr9}, 9);
  assign next10 = lfsrNext(lfsr10, 10);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      lfsr8 <= '1;
      lfsr9 <= '1;
      lfsr10 <= '1;
    end
    else if (step)
    begin
      lfsr8 <= next8[7:0];
      lfsr9 <= next9[8:0];
      lfsr10 <= next10;
    end
  end

  assign noise = {1'b0, lfsr10} + {2'b00, lfsr9} + {3'b000, lfsr8}; // max 1789

endmodule

/* verilog/radarPkg.sv */
// ##########################################################################
// shared types and constants of the sea clutter simulator
// imported by wildcard in the module headers that need them
// ##########################################################################
package radarPkg;

  typedef logic [11:0] videoT;    // 4095 means saturated or transmitting
  typedef logic [10:0] noiseT;
  typedef logic [10:0] rangeBinT; // saturates at all ones
  typedef logic [23:0] dacWordT;

  typedef enum logic [1:0] {serIdle, serLow, serHigh} serState;

  localparam logic [3:0] dacCmd = 4'd3;   // update the selected output now
  localparam logic [3:0] dacAddr = 4'd15; // all outputs
  localparam int dacFrameBits = 24;

  localparam int outlinePoints = 15;

  // start bin of each band, outline level is held until the next one
  localparam rangeBinT outlineBins [outlinePoints] = '{
    0, 13, 23, 32, 40, 50, 61, 76, 130, 180, 254, 300, 460, 1023, 1600
  };

  localparam videoT outlineLevels [outlinePoints] = '{
    4048, 3000, 2417, 2008, 1716, 1427, 1166, 889, 400, 217, 100, 66, 20, 1, 0
  };

  // noise right shift per band, far range gets almost nothing
  localparam logic [3:0] bandShift [outlinePoints] = '{
    0, 1, 1, 1, 1, 2, 2, 3, 4, 5, 6, 7, 8, 9, 10
  };

endpackage

/* verilog/radarTop.sv */
// ##########################################################################
// radar simulator top, azimuth and trigger timing, clutter video, DAC link
// ##########################################################################
`timescale 1ns/1ps

module radarTop
  import radarPkg::*;
#(
  parameter int acpPeriod = 24413,
  parameter int acpHigh = 245,
  parameter int azimuthBits = 12,
  parameter int trigPeriod = 24413,
  parameter int trigHigh = 51
) (
  input  logic  clk,
  input  logic  rst,
  output logic  acp,
  output logic  arp,
  output logic  trig,
  output videoT video,
  output logic  dacCs,
  output logic  dacSclk,
  output logic  dacSdi,
  output logic  dacClr
);

  azimuthGen #(
    .acpPeriod   (acpPeriod),
    .acpHigh     (acpHigh),
    .azimuthBits (azimuthBits)
  ) uAzimuth (
    .clk (clk),
    .rst (rst),
    .acp (acp),
    .arp (arp)
  );

  masterTrigger #(
    .trigPeriod (trigPeriod),
    .trigHigh   (trigHigh)
  ) uTrigger (
    .clk  (clk),
    .rst  (rst),
    .arp  (arp),
    .trig (trig)
  );

  clutterVideo uVideo (
    .clk   (clk),
    .rst   (rst),
    .trig  (trig),
    .video (video)
  );

  dacSerializer uDac (
    .clk     (clk),
    .rst     (rst),
    .video   (video),
    .dacCs   (dacCs),
    .dacSclk (dacSclk),
    .dacSdi  (dacSdi)
  );

  assign dacClr = rst; // DAC outputs cleared with the system

endmodule
